// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --assert --timing -j 0
TOP       := mmu_tb
FILELIST  := mmu.f
OBJ_DIR   := obj_dir
LOG       := sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove build output and log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "Checks failed" $(LOG); then \
		echo "TEST FAILED"; exit 1; \
	elif ! grep -q "All checks passed" $(LOG); then \
		echo "TEST FAILED: no result line"; exit 1; \
	else \
		echo "TEST PASSED"; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: mmu.f
+incdir+src
src/mmu_pkg.sv
src/dtlb.sv
src/mmu_fault_check.sv
src/mmu_top.sv
verif/mmu_assert.sv
verif/mmu_tb.sv

// File: src/dtlb.sv
/*
  Fully associative data TLB
  - parallel tag compare with registered hit and entry
  - lowest matching index wins
  - round-robin replacement on fill
  - flush clears all valid bits
*/

`include "mmu_params.svh"

module dtlb
  #(parameter int els_p = `MMU_DTLB_ENTRIES)
  (input  logic                        clk_i
   , input  logic                      reset_i
   , input  logic                      flush_i

   , input  logic                      r_v_i
   , input  logic [`MMU_VTAG_WIDTH-1:0] r_vtag_i

   , input  logic                      w_v_i
   , input  logic [`MMU_VTAG_WIDTH-1:0] w_vtag_i
   , input  mmu_pkg::tlb_entry_s       w_entry_i

   , output logic                      r_hit_o
   , output mmu_pkg::tlb_entry_s       r_entry_o
   );

  import mmu_pkg::*;

  localparam int ptr_width_lp = (els_p > 1) ? $clog2(els_p) : 1;

  logic [els_p-1:0]           valid_r;
  logic [`MMU_VTAG_WIDTH-1:0] tag_r [els_p];
  tlb_entry_s                 entry_r [els_p];
  logic [ptr_width_lp-1:0]    ptr_r;

  logic                       hit;
  tlb_entry_s                 hit_entry;

  logic                       r_hit_r;
  tlb_entry_s                 r_entry_r;

  // Valid bits and replacement pointer
  always_ff @(posedge clk_i) begin
    if (reset_i || flush_i) begin
      valid_r <= '0;
      ptr_r   <= '0;
    end else if (w_v_i) begin
      valid_r[ptr_r] <= 1'b1;
      if (ptr_r == ptr_width_lp'(els_p - 1)) begin
        ptr_r <= '0;
      end else begin
        ptr_r <= ptr_r + 1'b1;
      end
    end
  end

  // Tag and entry storage
  always_ff @(posedge clk_i) begin
    if (w_v_i) begin
      tag_r[ptr_r]   <= w_vtag_i;
      entry_r[ptr_r] <= w_entry_i;
    end
  end

  // Scan downward so the lowest index is the last to assign
  always_comb begin
    hit       = 1'b0;
    hit_entry = entry_r[0];
    for (int i = els_p - 1; i >= 0; i--) begin
      if (valid_r[i] && (tag_r[i] == r_vtag_i)) begin
        hit       = 1'b1;
        hit_entry = entry_r[i];
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      r_hit_r <= 1'b0;
    end else begin
      r_hit_r <= r_v_i & hit;
    end
  end

  always_ff @(posedge clk_i) begin
    if (r_v_i) begin
      r_entry_r <= hit_entry;
    end
  end

  assign r_hit_o   = r_hit_r;
  assign r_entry_o = r_entry_r;

endmodule

// File: src/mmu_fault_check.sv
/*
  Outcome classification of a translated access
  - miss when translation is on and the TLB missed
  - privilege and write checks on the leaf entry
  - domain and uncached-mode checks on the physical page number
*/

`include "mmu_params.svh"

module mmu_fault_check
  (input  logic                        store_i
   , input  logic                      translation_en_i
   , input  logic                      hit_i
   , input  mmu_pkg::priv_mode_e       priv_mode_i
   , input  logic                      sum_i
   , input  logic                      uncached_mode_i
   , input  mmu_pkg::tlb_entry_s       entry_i
   , input  logic [`MMU_PTAG_WIDTH-1:0] ptag_i

   , output logic                      miss_o
   , output logic                      load_page_fault_o
   , output logic                      store_page_fault_o
   , output logic                      access_fault_o
   );

  import mmu_pkg::*;

  logic                      translated;
  logic                      priv_fault;
  logic                      write_fault;
  logic [`MMU_DID_WIDTH-1:0] did;
  logic                      domain_fault;

  assign translated = translation_en_i & hit_i;

  // Supervisor may touch user pages only with SUM set
  assign priv_fault = ((priv_mode_i == e_priv_supervisor) & ~sum_i & entry_i.u)
                    | ((priv_mode_i == e_priv_user) & ~entry_i.u);

  assign write_fault = ~entry_i.w | ~entry_i.d;

  // Domain 0 is cached memory, domain 1 is I/O
  assign did          = ptag_i[`MMU_PTAG_WIDTH-1 -: `MMU_DID_WIDTH];
  assign domain_fault = (did > `MMU_DID_WIDTH'(1))
                      | (uncached_mode_i & (did == '0));

  assign miss_o             = translation_en_i & ~hit_i;
  assign load_page_fault_o  = translated & ~store_i & priv_fault;
  assign store_page_fault_o = translated & store_i & (priv_fault | write_fault);

  // Lowest priority outcome
  assign access_fault_o = domain_fault & ~miss_o & ~load_page_fault_o & ~store_page_fault_o;

endmodule

// File: src/mmu_params.svh
/*
  Address-translation parameters for the load/store front end
  - virtual and physical address widths
  - page offset and page number widths
  - data TLB depth
  - domain field width at the top of the physical page number
*/

`ifndef MMU_PARAMS_SVH
`define MMU_PARAMS_SVH

// Virtual address split into page number and offset
`define MMU_VADDR_WIDTH 32
`define MMU_PAGE_OFFSET_WIDTH 12
`define MMU_VTAG_WIDTH 20

// Physical page number plus the same offset
`define MMU_PTAG_WIDTH 16
`define MMU_PADDR_WIDTH 28

// Fully associative, small
`define MMU_DTLB_ENTRIES 8

// Domain bits are the top of the physical page number
`define MMU_DID_WIDTH 2

`endif

// File: src/mmu_pkg.sv
/*
  Shared types of the translation front end
  - privilege level encoding
  - leaf entry held by the data TLB
*/

`include "mmu_params.svh"

package mmu_pkg;

  // Same encoding as the privileged spec, hypervisor level unused
  typedef enum logic [1:0] {
    e_priv_user       = 2'd0,
    e_priv_supervisor = 2'd1,
    e_priv_machine    = 2'd3
  } priv_mode_e;

  // Leaf translation, 19 bits
  typedef struct packed {
    logic [`MMU_PTAG_WIDTH-1:0] ptag;
    // User accessible page
    logic                       u;
    // Writable page
    logic                       w;
    // Page already written, stores fault when clear
    logic                       d;
  } tlb_entry_s;

endpackage

// File: src/mmu_top.sv
/*
  Translation front end of the load/store unit
  - stage 1 command registers alongside the TLB lookup
  - poison kill, translated or passthrough page number
  - stage 2 fault classification
  - registered response two cycles after the command
*/

`include "mmu_params.svh"

module mmu_top
  (input  logic                          clk_i
   , input  logic                        reset_i

   , input  logic                        cmd_v_i
   , input  logic                        cmd_store_i
   , input  logic [`MMU_VADDR_WIDTH-1:0] cmd_vaddr_i

   , input  logic                        poison_i

   , input  mmu_pkg::priv_mode_e         priv_mode_i
   , input  logic                        sum_i
   , input  logic                        translation_en_i
   , input  logic                        uncached_mode_i

   , input  logic                        fill_v_i
   , input  logic [`MMU_VTAG_WIDTH-1:0]  fill_vtag_i
   , input  mmu_pkg::tlb_entry_s         fill_entry_i

   , input  logic                        flush_i

   , output logic                        resp_v_o
   , output logic [`MMU_PADDR_WIDTH-1:0] resp_paddr_o
   , output logic                        resp_miss_o
   , output logic                        resp_load_page_fault_o
   , output logic                        resp_store_page_fault_o
   , output logic                        resp_access_fault_o
   );

  import mmu_pkg::*;

  // Stage 1 keeps only the address bits a physical address can use
  logic                         s1_v_r;
  logic                         s1_store_r;
  logic [`MMU_PADDR_WIDTH-1:0]  s1_vaddr_r;

  logic                         dtlb_hit;
  tlb_entry_s                   dtlb_entry;
  logic [`MMU_PTAG_WIDTH-1:0]   s1_ptag;

  logic                         s2_v_r;
  logic                         s2_store_r;
  logic                         s2_hit_r;
  tlb_entry_s                   s2_entry_r;
  logic [`MMU_PADDR_WIDTH-1:0]  s2_paddr_r;

  logic                         miss;
  logic                         load_page_fault;
  logic                         store_page_fault;
  logic                         access_fault;

  logic                         resp_v_r;
  logic [`MMU_PADDR_WIDTH-1:0]  resp_paddr_r;
  logic                         resp_miss_r;
  logic                         resp_load_page_fault_r;
  logic                         resp_store_page_fault_r;
  logic                         resp_access_fault_r;

  dtlb #(.els_p(`MMU_DTLB_ENTRIES)) dtlb_inst
    (.clk_i(clk_i)
     ,.reset_i(reset_i)
     ,.flush_i(flush_i)
     ,.r_v_i(cmd_v_i)
     ,.r_vtag_i(cmd_vaddr_i[`MMU_VADDR_WIDTH-1 -: `MMU_VTAG_WIDTH])
     ,.w_v_i(fill_v_i)
     ,.w_vtag_i(fill_vtag_i)
     ,.w_entry_i(fill_entry_i)
     ,.r_hit_o(dtlb_hit)
     ,.r_entry_o(dtlb_entry)
     );

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      s1_v_r <= 1'b0;
    end else begin
      s1_v_r <= cmd_v_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (cmd_v_i) begin
      s1_store_r <= cmd_store_i;
      s1_vaddr_r <= cmd_vaddr_i[`MMU_PADDR_WIDTH-1:0];
    end
  end

  // Passthrough also covers a miss
  assign s1_ptag = (translation_en_i & dtlb_hit)
                 ? dtlb_entry.ptag
                 : s1_vaddr_r[`MMU_PADDR_WIDTH-1 -: `MMU_PTAG_WIDTH];

  // Poison kills the command held in stage 1
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      s2_v_r <= 1'b0;
    end else begin
      s2_v_r <= s1_v_r & ~poison_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (s1_v_r) begin
      s2_store_r <= s1_store_r;
      s2_hit_r   <= dtlb_hit;
      s2_entry_r <= dtlb_entry;
      s2_paddr_r <= {s1_ptag, s1_vaddr_r[`MMU_PAGE_OFFSET_WIDTH-1:0]};
    end
  end

  mmu_fault_check fault_check_inst
    (.store_i(s2_store_r)
     ,.translation_en_i(translation_en_i)
     ,.hit_i(s2_hit_r)
     ,.priv_mode_i(priv_mode_i)
     ,.sum_i(sum_i)
     ,.uncached_mode_i(uncached_mode_i)
     ,.entry_i(s2_entry_r)
     ,.ptag_i(s2_paddr_r[`MMU_PADDR_WIDTH-1 -: `MMU_PTAG_WIDTH])
     ,.miss_o(miss)
     ,.load_page_fault_o(load_page_fault)
     ,.store_page_fault_o(store_page_fault)
     ,.access_fault_o(access_fault)
     );

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      resp_v_r <= 1'b0;
    end else begin
      resp_v_r <= s2_v_r;
    end
  end

  always_ff @(posedge clk_i) begin
    if (s2_v_r) begin
      resp_paddr_r            <= s2_paddr_r;
      resp_miss_r             <= miss;
      resp_load_page_fault_r  <= load_page_fault;
      resp_store_page_fault_r <= store_page_fault;
      resp_access_fault_r     <= access_fault;
    end
  end

  assign resp_v_o                = resp_v_r;
  assign resp_paddr_o            = resp_paddr_r;
  assign resp_miss_o             = resp_miss_r;
  assign resp_load_page_fault_o  = resp_load_page_fault_r;
  assign resp_store_page_fault_o = resp_store_page_fault_r;
  assign resp_access_fault_o     = resp_access_fault_r;

endmodule

// File: verif/mmu_assert.sv
/*
  Protocol checks on the translation front end
  - no command and fill in the same cycle
  - at most one outcome flag per response
  - quiet response right after reset
  - fixed two-cycle latency for unpoisoned commands
*/

module mmu_assert
  (input  logic   clk_i
   , input  logic reset_i
   , input  logic cmd_v_i
   , input  logic fill_v_i
   , input  logic poison_i
   , input  logic resp_v_o
   , input  logic resp_miss_o
   , input  logic resp_load_page_fault_o
   , input  logic resp_store_page_fault_o
   , input  logic resp_access_fault_o
   );

  no_cmd_with_fill: assert property (@(posedge clk_i) disable iff (reset_i)
    !(cmd_v_i && fill_v_i))
    else $error("command and fill strobes high in the same cycle");

  one_outcome: assert property (@(posedge clk_i) disable iff (reset_i)
    resp_v_o |-> $onehot0({resp_miss_o, resp_load_page_fault_o,
                           resp_store_page_fault_o, resp_access_fault_o}))
    else $error("more than one outcome flag on a response");

  quiet_after_reset: assert property (@(posedge clk_i) reset_i |=> !resp_v_o)
    else $error("response valid in the cycle after reset");

  // Response sampled one edge after it is registered
  fixed_latency: assert property (@(posedge clk_i) disable iff (reset_i)
    cmd_v_i ##1 !poison_i |-> ##2 resp_v_o)
    else $error("unpoisoned command produced no response");

endmodule

bind mmu_top mmu_assert mmu_assert_inst (.*);

// File: verif/mmu_tb.sv
/*
  Testbench for the translation front end
  - clock, reset and LFSR stimulus
  - model TLB and reference outcome function
  - response queue with a comparing process and a watchdog
*/

`include "mmu_params.svh"

module mmu_tb;

  import mmu_pkg::*;

  typedef struct packed {
    logic [`MMU_PADDR_WIDTH-1:0] paddr;
    logic miss;
    logic lpf;
    logic spf;
    logic af;
  } resp_s;

  localparam int n_off_lp     = 24;
  localparam int n_rand_lp    = 100;
  localparam int n_batches_lp = 4;
  localparam int planned_lp   = 310 + n_off_lp + n_batches_lp * (n_rand_lp + 12);
  localparam int margin_lp    = 100;

  logic clk_i = 1'b0;
  logic reset_i;
  logic cmd_v_i;
  logic cmd_store_i;
  logic [`MMU_VADDR_WIDTH-1:0] cmd_vaddr_i;
  logic poison_i;
  priv_mode_e priv_mode_i;
  logic sum_i;
  logic translation_en_i;
  logic uncached_mode_i;
  logic fill_v_i;
  logic [`MMU_VTAG_WIDTH-1:0] fill_vtag_i;
  tlb_entry_s fill_entry_i;
  logic flush_i;
  logic resp_v_o;
  logic [`MMU_PADDR_WIDTH-1:0] resp_paddr_o;
  logic resp_miss_o;
  logic resp_load_page_fault_o;
  logic resp_store_page_fault_o;
  logic resp_access_fault_o;

  logic [31:0] lfsr_state = 32'h5d66_c5b3;
  logic [`MMU_VTAG_WIDTH-1:0] model_tag [`MMU_DTLB_ENTRIES];
  tlb_entry_s model_entry [`MMU_DTLB_ENTRIES];
  logic [`MMU_DTLB_ENTRIES-1:0] model_valid;
  int model_ptr;
  priv_mode_e lvl_priv;
  logic lvl_sum;
  logic lvl_trans;
  logic lvl_unc;
  resp_s exp_q [$];
  resp_s pend_exp;
  logic pend_v;

  always #10 clk_i = ~clk_i;

  mmu_top mmu_top_inst
    (.clk_i(clk_i), .reset_i(reset_i)
     , .cmd_v_i(cmd_v_i), .cmd_store_i(cmd_store_i), .cmd_vaddr_i(cmd_vaddr_i)
     , .poison_i(poison_i)
     , .priv_mode_i(priv_mode_i), .sum_i(sum_i)
     , .translation_en_i(translation_en_i), .uncached_mode_i(uncached_mode_i)
     , .fill_v_i(fill_v_i), .fill_vtag_i(fill_vtag_i), .fill_entry_i(fill_entry_i)
     , .flush_i(flush_i)
     , .resp_v_o(resp_v_o), .resp_paddr_o(resp_paddr_o), .resp_miss_o(resp_miss_o)
     , .resp_load_page_fault_o(resp_load_page_fault_o)
     , .resp_store_page_fault_o(resp_store_page_fault_o)
     , .resp_access_fault_o(resp_access_fault_o));

  // Taps 32, 22, 2, 1
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_state = {lfsr_state[30:0],
                    lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0]};
      r = {r[30:0], lfsr_state[0]};
    end
    return r;
  endfunction

  function automatic priv_mode_e pick_priv();
    logic [1:0] r;
    r = 2'(rand_bits(2));
    return (r[1]) ? e_priv_machine : priv_mode_e'(r);
  endfunction

  // Expected outcome from the model TLB and the current levels
  function automatic resp_s expected_response(input logic st, input logic [31:0] va);
    resp_s e;
    logic found;
    tlb_entry_s ent;
    logic [15:0] ptag;
    logic pf_priv;
    logic pf;
    logic [1:0] dom;
    found = 1'b0;
    ent = '0;
    for (int i = 0; i < `MMU_DTLB_ENTRIES; i++) begin
      if (!found && model_valid[i] && model_tag[i] == va[31:12]) begin
        found = 1'b1;
        ent = model_entry[i];
      end
    end
    ptag = (lvl_trans && found) ? ent.ptag : va[27:12];
    e.paddr = {ptag, va[11:0]};
    e.miss = lvl_trans && !found;
    pf_priv = (lvl_priv == e_priv_user) ? !ent.u
            : (lvl_priv == e_priv_supervisor) ? (ent.u && !lvl_sum) : 1'b0;
    e.lpf = lvl_trans && found && !st && pf_priv;
    e.spf = lvl_trans && found && st && (pf_priv || !ent.w || !ent.d);
    pf = e.lpf || e.spf;
    dom = ptag[15:14];
    e.af = !e.miss && !pf && (dom >= 2'd2 || (dom == 2'd0 && lvl_unc));
    return e;
  endfunction

  task automatic stop_with_failure();
    $display("Checks failed");
    $fatal(1);
  endtask

  task automatic check_field(input string name, input logic [31:0] exp, input logic [31:0] act);
    assert (exp === act)
    else begin
      $display("Mismatch at time %0t: %s expected 0x%0h, got 0x%0h", $time, name, exp, act);
      stop_with_failure();
    end
  endtask

  // One clock cycle of stimulus; poison applies to the previous cycle's command
  task automatic drive_cycle(input logic cv, input logic st, input logic [31:0] va,
                             input logic pz, input logic fv, input logic [19:0] ft,
                             input tlb_entry_s fe, input logic fl);
    @(posedge clk_i);
    if (pend_v && !pz) exp_q.push_back(pend_exp);
    pend_v = cv;
    if (cv) pend_exp = expected_response(st, va);
    if (fl) begin
      model_valid = '0;
      model_ptr = 0;
    end else if (fv) begin
      model_tag[model_ptr] = ft;
      model_entry[model_ptr] = fe;
      model_valid[model_ptr] = 1'b1;
      model_ptr = (model_ptr + 1) % `MMU_DTLB_ENTRIES;
    end
    cmd_v_i <= cv;
    cmd_store_i <= st;
    cmd_vaddr_i <= va;
    poison_i <= pz;
    fill_v_i <= fv;
    fill_vtag_i <= ft;
    fill_entry_i <= fe;
    flush_i <= fl;
    priv_mode_i <= lvl_priv;
    sum_i <= lvl_sum;
    translation_en_i <= lvl_trans;
    uncached_mode_i <= lvl_unc;
  endtask

  task automatic issue(input logic st, input logic [31:0] va, input logic pz);
    drive_cycle(1'b1, st, va, pz, 1'b0, '0, '0, 1'b0);
  endtask

  task automatic fill_tlb(input logic [19:0] t, input tlb_entry_s e);
    drive_cycle(1'b0, 1'b0, '0, 1'b0, 1'b1, t, e, 1'b0);
  endtask

  task automatic idle_cycle(input logic pz);
    drive_cycle(1'b0, 1'b0, '0, pz, 1'b0, '0, '0, 1'b0);
  endtask

  task automatic flush_tlb();
    drive_cycle(1'b0, 1'b0, '0, 1'b0, 1'b0, '0, '0, 1'b1);
  endtask

  // Levels may change only after this
  task automatic drain();
    idle_cycle(1'b0);
    while (pend_v || exp_q.size() != 0) idle_cycle(1'b0);
  endtask

  always @(posedge clk_i) begin
    resp_s e;
    if (!reset_i && resp_v_o) begin
      if (exp_q.size() == 0) begin
        $display("Response at time %0t with no command outstanding", $time);
        stop_with_failure();
      end else begin
        e = exp_q.pop_front();
        check_field("resp_paddr_o", 32'(e.paddr), 32'(resp_paddr_o));
        check_field("resp_miss_o", 32'(e.miss), 32'(resp_miss_o));
        check_field("resp_load_page_fault_o", 32'(e.lpf), 32'(resp_load_page_fault_o));
        check_field("resp_store_page_fault_o", 32'(e.spf), 32'(resp_store_page_fault_o));
        check_field("resp_access_fault_o", 32'(e.af), 32'(resp_access_fault_o));
      end
    end
  end

  initial begin
    repeat (planned_lp + margin_lp) @(posedge clk_i);
    $display("Timeout after %0d cycles, responses did not drain", planned_lp + margin_lp);
    stop_with_failure();
  end

  initial begin
    reset_i = 1'b1;
    cmd_v_i = 1'b0;
    cmd_store_i = 1'b0;
    cmd_vaddr_i = '0;
    poison_i = 1'b0;
    priv_mode_i = e_priv_machine;
    sum_i = 1'b0;
    translation_en_i = 1'b0;
    uncached_mode_i = 1'b0;
    fill_v_i = 1'b0;
    fill_vtag_i = '0;
    fill_entry_i = '0;
    flush_i = 1'b0;
    model_valid = '0;
    model_ptr = 0;
    pend_v = 1'b0;
    lvl_priv = e_priv_machine;
    lvl_sum = 1'b0;
    lvl_trans = 1'b0;
    lvl_unc = 1'b0;
    repeat (4) @(posedge clk_i);
    reset_i <= 1'b0;

    // Passthrough with translation off
    for (int u = 0; u < 2; u++) begin
      lvl_unc = u[0];
      for (int i = 0; i < n_off_lp / 2; i++) begin
        issue(1'(rand_bits(1)), rand_bits(32), 1'b0);
      end
      drain();
    end

    // Miss, fill, hit, flush, then wrap of the fill pointer
    lvl_trans = 1'b1;
    lvl_unc = 1'b0;
    issue(1'b0, 32'h0001_2345, 1'b0);
    fill_tlb(20'h00012, tlb_entry_s'({16'h0abc, 3'b011}));
    issue(1'b1, 32'h0001_2345, 1'b0);
    flush_tlb();
    issue(1'b0, 32'h0001_2345, 1'b0);
    for (int i = 0; i < 9; i++) begin
      fill_tlb(20'(20'h00100 + i), tlb_entry_s'({16'(16'h1000 + i), 3'b011}));
    end
    issue(1'b0, 32'h0010_0010, 1'b0);
    issue(1'b0, 32'h0010_1020, 1'b0);
    issue(1'b1, 32'h0010_8030, 1'b0);
    drain();

    // Page faults over every privilege, SUM and permission combination
    flush_tlb();
    for (int i = 0; i < 8; i++) begin
      fill_tlb(20'(20'h10000 + i), tlb_entry_s'({2'b00, 14'(i * 37 + 5), 3'(i)}));
    end
    for (int p = 0; p < 3; p++) begin
      for (int s = 0; s < 2; s++) begin
        lvl_priv = (p == 2) ? e_priv_machine : priv_mode_e'(p);
        lvl_sum = s[0];
        for (int i = 0; i < 16; i++) issue(i[0], {20'(20'h10000 + i / 2), 12'(i * 16)}, 1'b0);
        drain();
      end
    end

    // Domains, with page-fault and miss suppression
    flush_tlb();
    for (int i = 0; i < 8; i++) begin
      fill_tlb(20'(20'h20000 + i), tlb_entry_s'({2'(i % 4), 14'(i * 11), i < 4, 2'b11}));
    end
    lvl_priv = e_priv_user;
    lvl_sum = 1'b0;
    for (int u = 0; u < 2; u++) begin
      lvl_unc = u[0];
      for (int i = 0; i < 16; i++) issue(i[0], {20'(20'h20000 + i / 2), 12'h0}, 1'b0);
      issue(1'b0, {4'h0, 2'b10, 14'h123, 12'h0}, 1'b0);
      drain();
    end

    // Poison and random back-to-back traffic
    flush_tlb();
    for (int i = 0; i < 8; i++) fill_tlb(20'(20'h40000 + i), tlb_entry_s'(19'(rand_bits(19))));
    for (int b = 0; b < n_batches_lp; b++) begin
      lvl_priv = pick_priv();
      lvl_sum = 1'(rand_bits(1));
      lvl_trans = 1'(rand_bits(1));
      lvl_unc = 1'(rand_bits(1));
      issue(1'b0, 32'h4000_0100, 1'b0);
      idle_cycle(1'b1);
      issue(1'b1, 32'h4000_1200, 1'b0);
      issue(1'b0, 32'h4000_2300, 1'b1);
      for (int j = 0; j < n_rand_lp; j++) begin
        if (rand_bits(2) != 0)
          issue(1'(rand_bits(1)), {20'(20'h40000 + rand_bits(4)), 12'(rand_bits(12))},
                rand_bits(2) == 0);
        else
          idle_cycle(rand_bits(2) == 0);
      end
      drain();
    end

    repeat (3) idle_cycle(1'b0);
    $display("All checks passed");
    $finish;
  end

endmodule
